// File: verilog/rvfi_mon_pkg.sv
// Shared types and helpers for the RVFI monitor. Two memory lanes of 4 bytes each
// and 16-bit saturating counters are assumed throughout.
package rvfi_mon_pkg;

  localparam int NMEM = 2;
  localparam int LANE_W = 4;
  localparam int MASK_W = NMEM * LANE_W;
  localparam int CNT_W = 16;
  localparam int NUM_RULES = 8;

  // Rule numbering also sets the priority for first_rule, lowest wins
  typedef enum logic [2:0] {
    RULE_DBG_CAUSE        = 3'd0,
    RULE_EXC_CAUSE        = 3'd1,
    RULE_EXC_MCAUSE       = 3'd2,
    RULE_IRQ_CAUSE        = 3'd3,
    RULE_HANDLER_AMBIG    = 3'd4,
    RULE_SYNC_UNANNOUNCED = 3'd5,
    RULE_EXC_NO_CAUSE     = 3'd6,
    RULE_MEM_OVERREPORT   = 3'd7
  } rule_idx_t;

  typedef logic [NUM_RULES-1:0] viol_vec_t;

  typedef struct packed {
    logic              valid;
    logic [2:0]        dbg;
    logic              dbg_mode;
    logic [31:0]       dcsr_rdata;
    logic              trap_exception;
    logic [5:0]        exception_cause;
    logic              intr_interrupt;
    logic              intr_exception;
    logic [10:0]       intr_cause;
    logic [31:0]       mcause_wdata;
    logic [31:0]       mcause_wmask;
    logic [MASK_W-1:0] mem_rmask;
    logic [MASK_W-1:0] mem_wmask;
  } retire_rec_t;

  // Record plus what the previous valid retirement left behind
  typedef struct packed {
    retire_rec_t rec;
    logic        prev_dbg_mode;
    logic        prev_exception;
  } cap_rec_t;

  typedef struct packed {
    logic bus_valid;
    logic bus_ready;
  } bus_evt_t;

  // CLINT takes the fixed standard set, CLIC any ID below 2**id_width.
  // NMI causes 1024..1027 are legal in both modes
  function automatic logic irq_cause_legal(input logic [10:0] cause, input bit clic,
                                           input int unsigned id_width);
    logic [31:0] max_id;
    logic        legal;
    max_id = (32'd1 << id_width) - 32'd1;
    if (cause inside {[11'd1024:11'd1027]}) begin
      legal = 1'b1;
    end else if (clic) begin
      legal = ({21'd0, cause} <= max_id);
    end else begin
      legal = cause inside {11'd3, 11'd7, 11'd11, [11'd16:11'd31]};
    end
    return legal;
  endfunction

  function automatic logic [CNT_W-1:0] cnt_sat_add(input logic [CNT_W-1:0] a,
                                                   input logic [CNT_W-1:0] b);
    logic [CNT_W:0] sum;
    sum = {1'b0, a} + {1'b0, b};
    return sum[CNT_W] ? '1 : sum[CNT_W-1:0];
  endfunction

endpackage

// File: verilog/retire_capture.sv
// Registers every retirement record. History tracks valid records only, so
// idle cycles between retirements do not disturb it.
`timescale 1ns/10ps

module retire_capture (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  rvfi_mon_pkg::retire_rec_t rec,
  output rvfi_mon_pkg::cap_rec_t    cap
);

  import rvfi_mon_pkg::*;

  retire_rec_t rec_q;
  logic        valid_q;

  // Running context from the last valid retirement
  logic        prev_dbg_mode_q;
  logic        prev_exception_q;

  // Context as it was before the captured record
  logic        cap_prev_dbg_mode_q;
  logic        cap_prev_exception_q;

  // Payload only, qualified by valid_q
  always_ff @(posedge clk_i) begin
    rec_q <= rec;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q              <= 1'b0;
      prev_dbg_mode_q      <= 1'b0;
      prev_exception_q     <= 1'b0;
      cap_prev_dbg_mode_q  <= 1'b0;
      cap_prev_exception_q <= 1'b0;
    end else begin
      valid_q              <= rec.valid;
      cap_prev_dbg_mode_q  <= prev_dbg_mode_q;
      cap_prev_exception_q <= prev_exception_q;
      if (rec.valid) begin
        prev_dbg_mode_q  <= rec.dbg_mode;
        prev_exception_q <= rec.trap_exception;
      end
    end
  end

  always_comb begin
    cap.rec            = rec_q;
    cap.rec.valid      = valid_q;
    cap.prev_dbg_mode  = cap_prev_dbg_mode_q;
    cap.prev_exception = cap_prev_exception_q;
  end

endmodule

// File: verilog/cause_rules.sv
// Evaluates rules 0..6 on one captured record, one cycle of latency.
// Bit 7 of the output vector is always zero, mem_count_rule owns it.
`timescale 1ns/10ps

module cause_rules #(
  parameter bit          clic          = 1'b0,
  parameter int unsigned clic_id_width = 5
) (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  rvfi_mon_pkg::cap_rec_t  cap,
  output rvfi_mon_pkg::viol_vec_t cause_viol,
  output logic                   cause_valid
);

  import rvfi_mon_pkg::*;

  viol_vec_t   viol_d;
  logic [31:0] mcause_masked;
  logic [10:0] mcause_exccode;
  logic        exc_outside_dbg;

  assign mcause_masked   = cap.rec.mcause_wdata & cap.rec.mcause_wmask;
  assign mcause_exccode  = mcause_masked[10:0];
  assign exc_outside_dbg = cap.rec.trap_exception && !cap.rec.dbg_mode;

  always_comb begin
    viol_d = '0;
    if (cap.rec.valid) begin
      // Entry into debug must report the same cause as dcsr
      viol_d[RULE_DBG_CAUSE] = (cap.rec.dbg != 3'd0) && !cap.prev_dbg_mode &&
                               (cap.rec.dbg != cap.rec.dcsr_rdata[8:6]);

      viol_d[RULE_EXC_CAUSE] = exc_outside_dbg &&
                               ({5'd0, cap.rec.exception_cause} != mcause_exccode);

      // mcause.interrupt has to be written, and written as zero
      viol_d[RULE_EXC_MCAUSE] = exc_outside_dbg &&
                                (!cap.rec.mcause_wmask[31] || cap.rec.mcause_wdata[31]);

      viol_d[RULE_IRQ_CAUSE] = cap.rec.intr_interrupt &&
                               !irq_cause_legal(cap.rec.intr_cause, clic, clic_id_width);

      viol_d[RULE_HANDLER_AMBIG] = cap.rec.intr_exception && cap.rec.intr_interrupt;

      // A synchronous handler follows a retired exception and nothing else
      viol_d[RULE_SYNC_UNANNOUNCED] = (cap.rec.intr_exception != cap.prev_exception) &&
                                      !cap.rec.intr_interrupt;

      viol_d[RULE_EXC_NO_CAUSE] = cap.rec.trap_exception &&
                                  (cap.rec.exception_cause == 6'd0);
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cause_viol  <= '0;
      cause_valid <= 1'b0;
    end else begin
      cause_viol  <= viol_d;
      cause_valid <= cap.rec.valid;
    end
  end

endmodule

// File: verilog/mem_count_rule.sv
// Compares reported memory accesses against completed bus handshakes.
// Both counts saturate, so a very long run stops being meaningful at 2**16-1.
`timescale 1ns/10ps

module mem_count_rule (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  rvfi_mon_pkg::cap_rec_t cap,
  input  rvfi_mon_pkg::bus_evt_t bus,
  output logic                  mem_viol
);

  import rvfi_mon_pkg::*;

  // Bus sampled alongside the record so both reach the counters together
  bus_evt_t         bus_q;
  logic [CNT_W-1:0] bus_cnt_q;
  logic [CNT_W-1:0] bus_cnt_n;
  logic [CNT_W-1:0] mem_cnt_q;
  logic [CNT_W-1:0] mem_cnt_n;
  logic [CNT_W-1:0] mem_new;
  logic [CNT_W-1:0] bus_new;

  always_comb begin
    mem_new = '0;
    if (cap.rec.valid) begin
      // One access per active lane and direction
      for (int i = 0; i < NMEM; i++) begin
        if (|cap.rec.mem_rmask[i*LANE_W +: LANE_W]) begin
          mem_new = mem_new + CNT_W'(1);
        end
        if (|cap.rec.mem_wmask[i*LANE_W +: LANE_W]) begin
          mem_new = mem_new + CNT_W'(1);
        end
      end
    end
    bus_new   = {{(CNT_W-1){1'b0}}, bus_q.bus_valid & bus_q.bus_ready};
    bus_cnt_n = cnt_sat_add(bus_cnt_q, bus_new);
    mem_cnt_n = cnt_sat_add(mem_cnt_q, mem_new);
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      bus_q     <= '0;
      bus_cnt_q <= '0;
      mem_cnt_q <= '0;
      mem_viol  <= 1'b0;
    end else begin
      bus_q     <= bus;
      bus_cnt_q <= bus_cnt_n;
      mem_cnt_q <= mem_cnt_n;
      // Judged with the current record and handshake already counted
      mem_viol  <= cap.rec.valid && (mem_cnt_n > bus_cnt_n);
    end
  end

endmodule

// File: verilog/violation_log.sv
// Sticky violation record. Clear wins over stored state but not over a
// violation arriving on the same edge.
`timescale 1ns/10ps

module violation_log (
  input  logic                             clk_i,
  input  logic                             rst_ni,
  input  rvfi_mon_pkg::viol_vec_t           cause_viol,
  input  logic                             cause_valid,
  input  logic                             mem_viol,
  input  logic                             clear,
  output rvfi_mon_pkg::viol_vec_t           viol_flags,
  output logic [rvfi_mon_pkg::CNT_W-1:0]    viol_count,
  output logic                             first_valid,
  output rvfi_mon_pkg::rule_idx_t           first_rule
);

  import rvfi_mon_pkg::*;

  viol_vec_t        all_viol;
  viol_vec_t        flags_base;
  logic [CNT_W-1:0] cnt_base;
  logic             first_base;
  logic             any_viol;
  rule_idx_t        low_idx;

  always_comb begin
    all_viol = '0;
    if (cause_valid) begin
      all_viol = cause_viol;
      all_viol[RULE_MEM_OVERREPORT] = mem_viol;
    end
    any_viol = |all_viol;

    // Scan downward so the lowest set rule is left in low_idx
    low_idx = RULE_DBG_CAUSE;
    for (int i = NUM_RULES - 1; i >= 0; i--) begin
      if (all_viol[i]) begin
        low_idx = rule_idx_t'(3'(i));
      end
    end

    flags_base = clear ? '0 : viol_flags;
    cnt_base   = clear ? '0 : viol_count;
    first_base = clear ? 1'b0 : first_valid;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      viol_flags  <= '0;
      viol_count  <= '0;
      first_valid <= 1'b0;
      first_rule  <= RULE_DBG_CAUSE;
    end else begin
      viol_flags  <= flags_base | all_viol;
      viol_count  <= any_viol ? cnt_sat_add(cnt_base, CNT_W'(1)) : cnt_base;
      first_valid <= first_base | any_viol;
      if (!first_base && any_viol) begin
        first_rule <= low_idx;
      end
    end
  end

endmodule

// File: verilog/rvfi_monitor_top.sv
// RVFI retirement monitor. Results appear three clocks after a record is driven;
// no back-pressure, every record is accepted.
`timescale 1ns/10ps

module rvfi_monitor_top #(
  parameter bit          clic          = 1'b0,
  parameter int unsigned clic_id_width = 5
) (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  rvfi_mon_pkg::retire_rec_t      rec,
  input  rvfi_mon_pkg::bus_evt_t         bus,
  input  logic                          clear,
  output rvfi_mon_pkg::viol_vec_t        viol_flags,
  output logic [rvfi_mon_pkg::CNT_W-1:0] viol_count,
  output logic                          first_valid,
  output rvfi_mon_pkg::rule_idx_t        first_rule
);

  import rvfi_mon_pkg::*;

  cap_rec_t  cap;
  viol_vec_t cause_viol;
  logic      cause_valid;
  logic      mem_viol;

  retire_capture capture_i (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .rec    (rec),
    .cap    (cap)
  );

  cause_rules #(
    .clic          (clic),
    .clic_id_width (clic_id_width)
  ) cause_i (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .cap         (cap),
    .cause_viol  (cause_viol),
    .cause_valid (cause_valid)
  );

  mem_count_rule mem_i (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .cap      (cap),
    .bus      (bus),
    .mem_viol (mem_viol)
  );

  violation_log log_i (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .cause_viol  (cause_viol),
    .cause_valid (cause_valid),
    .mem_viol    (mem_viol),
    .clear       (clear),
    .viol_flags  (viol_flags),
    .viol_count  (viol_count),
    .first_valid (first_valid),
    .first_rule  (first_rule)
  );

endmodule

// File: tests/clk_gen.sv
// 4 ns clock, reset held low for the first 2 cycles and released between edges
`timescale 1ns/10ps

module clk_gen (
  output logic clk_i,
  output logic rst_ni
);

  initial begin
    clk_i  = 1'b0;
    rst_ni = 1'b0;
    #8 rst_ni = 1'b1;
  end

  always #2 clk_i = ~clk_i;

endmodule

// File: tests/rvfi_monitor_checker.sv
// Bound into rvfi_monitor_top. Checks that the logged state only grows until a clear.
`timescale 1ns/10ps

module rvfi_monitor_checker (
  input logic                          clk_i,
  input logic                          rst_ni,
  input logic                          clear,
  input rvfi_mon_pkg::viol_vec_t        viol_flags,
  input logic [rvfi_mon_pkg::CNT_W-1:0] viol_count,
  input logic                          first_valid
);

  // Sticky flags keep every bit they had unless a clear was seen
  flags_sticky_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !$past(clear) |-> ((viol_flags & $past(viol_flags)) == $past(viol_flags)))
    else $error("viol_flags lost a bit without clear");

  count_monotonic_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !$past(clear) |-> (viol_count >= $past(viol_count)))
    else $error("viol_count decreased without clear");

  // First faulty retirement always brings at least one flag with it
  first_with_flag_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $rose(first_valid) |-> (viol_flags != '0))
    else $error("first_valid rose with no flag set");

endmodule

bind rvfi_monitor_top rvfi_monitor_checker checker_i (
  .clk_i       (clk_i),
  .rst_ni      (rst_ni),
  .clear       (clear),
  .viol_flags  (viol_flags),
  .viol_count  (viol_count),
  .first_valid (first_valid)
);

// File: tests/rvfi_monitor_tb.sv
// Random record stream in CLINT mode against a cycle model of the monitor.
// The first QUIET_CYCLES records carry no faults; the run ends with a clear.
`timescale 1ns/10ps

module rvfi_monitor_tb;

  import rvfi_mon_pkg::*;

  localparam int NUM_CYCLES = 2000;
  localparam int QUIET_CYCLES = 60;
  localparam int RESET_WAIT = 20;
  localparam int WATCHDOG_NS = 20000;
  localparam int CNT_MAX = 65535;

  logic             clk_i;
  logic             rst_ni;
  retire_rec_t      rec;
  bus_evt_t         bus;
  logic             clear;
  viol_vec_t        viol_flags;
  logic [CNT_W-1:0] viol_count;
  logic             first_valid;
  rule_idx_t        first_rule;

  // Model state
  viol_vec_t m_flags;
  int        m_count;
  logic      m_fv;
  rule_idx_t m_first;
  logic      m_prev_dbg;
  logic      m_prev_exc;
  int        m_bus_cnt;
  int        m_mem_cnt;
  viol_vec_t pipe [3];
  viol_vec_t cur_vec;
  logic      cur_clear;
  int        err_mismatch;
  int        err_other;

  clk_gen clk_gen_i (.clk_i(clk_i), .rst_ni(rst_ni));

  rvfi_monitor_top #(.clic(1'b0), .clic_id_width(5)) dut_i (
    .clk_i(clk_i), .rst_ni(rst_ni), .rec(rec), .bus(bus), .clear(clear),
    .viol_flags(viol_flags), .viol_count(viol_count),
    .first_valid(first_valid), .first_rule(first_rule)
  );

  function automatic logic clint_cause_ok(input logic [10:0] c);
    return (c == 11'd3) || (c == 11'd7) || (c == 11'd11) ||
           (c >= 11'd16 && c <= 11'd31) || (c >= 11'd1024 && c <= 11'd1027);
  endfunction

  task automatic check_flags(input viol_vec_t got, input viol_vec_t exp);
    if (got !== exp) begin
      $display("MISMATCH at %0t: viol_flags %b, expected %b", $time, got, exp);
      err_mismatch++;
    end
  endtask

  task automatic check_count(input logic [CNT_W-1:0] got, input logic [CNT_W-1:0] exp);
    if (got !== exp) begin
      $display("MISMATCH at %0t: viol_count %0d, expected %0d", $time, got, exp);
      err_mismatch++;
    end
  endtask

  task automatic check_first(input logic got_v, input rule_idx_t got,
                             input logic exp_v, input rule_idx_t exp);
    if (got_v !== exp_v || (exp_v && got !== exp)) begin
      $display("MISMATCH at %0t: first %b/%0d, expected %b/%0d",
               $time, got_v, got, exp_v, exp);
      err_mismatch++;
    end
  endtask

  // Rule vector of one driven record, counts and context advance with it
  task automatic predict_record(input retire_rec_t r, input bus_evt_t b,
                                output viol_vec_t v);
    logic [31:0] masked;
    logic        exc_nd;
    v = '0;
    if (b.bus_valid && b.bus_ready && m_bus_cnt < CNT_MAX) m_bus_cnt++;
    if (r.valid) begin
      masked = r.mcause_wdata & r.mcause_wmask;
      exc_nd = r.trap_exception && !r.dbg_mode;
      v[0] = (r.dbg != 3'd0) && !m_prev_dbg && (r.dbg != r.dcsr_rdata[8:6]);
      v[1] = exc_nd && ({5'd0, r.exception_cause} != masked[10:0]);
      v[2] = exc_nd && (!r.mcause_wmask[31] || r.mcause_wdata[31]);
      v[3] = r.intr_interrupt && !clint_cause_ok(r.intr_cause);
      v[4] = r.intr_interrupt && r.intr_exception;
      v[5] = (r.intr_exception != m_prev_exc) && !r.intr_interrupt;
      v[6] = r.trap_exception && (r.exception_cause == 6'd0);
      for (int i = 0; i < NMEM; i++) begin
        if (r.mem_rmask[i*LANE_W +: LANE_W] != '0) m_mem_cnt++;
        if (r.mem_wmask[i*LANE_W +: LANE_W] != '0) m_mem_cnt++;
      end
      if (m_mem_cnt > CNT_MAX) m_mem_cnt = CNT_MAX;
      v[7] = m_mem_cnt > m_bus_cnt;
      m_prev_dbg = r.dbg_mode;
      m_prev_exc = r.trap_exception;
    end
  endtask

  task automatic log_update(input viol_vec_t v, input logic clr);
    rule_idx_t low;
    logic      fv_base;
    low = RULE_DBG_CAUSE;
    for (int i = NUM_RULES - 1; i >= 0; i--) begin
      if (v[i]) low = rule_idx_t'(3'(i));
    end
    fv_base = clr ? 1'b0 : m_fv;
    m_flags = (clr ? '0 : m_flags) | v;
    if (clr) m_count = 0;
    if (v != '0 && m_count < CNT_MAX) m_count++;
    if (!fv_base && v != '0) m_first = low;
    m_fv = fv_base || (v != '0);
  endtask

  task automatic make_record(input bit allow_fault, output retire_rec_t r,
                             output bus_evt_t b);
    int slack;
    r = '0;
    b.bus_valid = 1'($urandom_range(0, 1));
    b.bus_ready = ($urandom_range(0, 3) != 0);
    r.valid = ($urandom_range(0, 9) != 0);
    slack = m_bus_cnt - m_mem_cnt + ((b.bus_valid && b.bus_ready) ? 1 : 0);
    r.dbg_mode = ($urandom_range(0, 7) == 0);
    r.dcsr_rdata = $urandom;
    if ($urandom_range(0, 5) == 0) begin
      r.dbg = 3'($urandom_range(1, 7));
      r.dcsr_rdata[8:6] = r.dbg;
    end
    r.mcause_wdata = $urandom;
    r.mcause_wmask = $urandom;
    if ($urandom_range(0, 4) == 0) begin
      r.trap_exception = 1'b1;
      r.exception_cause = 6'($urandom_range(1, 63));
      r.mcause_wmask = '1;
      r.mcause_wdata = {26'd0, r.exception_cause};
    end
    if (m_prev_exc) begin
      r.intr_exception = 1'b1;
    end else if ($urandom_range(0, 5) == 0) begin
      r.intr_interrupt = 1'b1;
      r.intr_cause = 11'($urandom_range(16, 31));
    end
    // Report accesses only while the bus has completed enough of them
    for (int i = 0; i < NMEM; i++) begin
      if (slack > 0 && $urandom_range(0, 1) == 1) begin
        r.mem_rmask[i*LANE_W +: LANE_W] = 4'($urandom_range(1, 15));
        slack--;
      end
      if (slack > 0 && $urandom_range(0, 1) == 1) begin
        r.mem_wmask[i*LANE_W +: LANE_W] = 4'($urandom_range(1, 15));
        slack--;
      end
    end
    if (allow_fault && $urandom_range(0, 7) == 0) begin
      case ($urandom_range(0, 7))
        0: begin
          r.dbg = 3'($urandom_range(1, 7));
          r.dcsr_rdata[8:6] = r.dbg ^ 3'($urandom_range(1, 7));
        end
        1: begin
          r.trap_exception = 1'b1;
          r.exception_cause = 6'($urandom_range(1, 63));
          r.mcause_wmask = '1;
          r.mcause_wdata = {26'd0, r.exception_cause ^ 6'($urandom_range(1, 63))};
        end
        2: begin
          r.trap_exception = 1'b1;
          r.exception_cause = 6'($urandom_range(1, 63));
          r.mcause_wmask = '1;
          r.mcause_wdata = {1'b1, 25'd0, r.exception_cause};
        end
        3: begin
          r.intr_interrupt = 1'b1;
          r.intr_exception = 1'b0;
          r.intr_cause = 11'($urandom_range(32, 1023));
        end
        4: begin
          r.intr_interrupt = 1'b1;
          r.intr_exception = 1'b1;
          r.intr_cause = 11'd7;
        end
        5: begin
          r.intr_interrupt = 1'b0;
          r.intr_exception = !m_prev_exc;
        end
        6: begin
          r.trap_exception = 1'b1;
          r.exception_cause = 6'd0;
          r.mcause_wmask = '1;
          r.mcause_wdata = '0;
        end
        default: begin
          r.mem_rmask = '1;
          r.mem_wmask = '1;
        end
      endcase
    end
  endtask

  initial begin
    #WATCHDOG_NS;
    $display("Simulation ran past its time limit");
    $display("Verification failed");
    $finish;
  end

  initial begin
    retire_rec_t r;
    bus_evt_t    b;
    rec = '0;
    bus = '0;
    clear = 1'b0;
    m_flags = '0;
    m_count = 0;
    m_fv = 1'b0;
    m_first = RULE_DBG_CAUSE;
    m_prev_dbg = 1'b0;
    m_prev_exc = 1'b0;
    m_bus_cnt = 0;
    m_mem_cnt = 0;
    pipe = '{default: '0};
    cur_vec = '0;
    cur_clear = 1'b0;
    err_mismatch = 0;
    err_other = 0;
    void'($urandom(32'ha5d5_9308));
    for (int i = 0; i < RESET_WAIT && !rst_ni; i++) @(posedge clk_i);
    if (!rst_ni) begin
      $display("Timeout while waiting for reset release");
      err_other++;
    end
    for (int cyc = 0; cyc < NUM_CYCLES + 4; cyc++) begin
      @(posedge clk_i);
      pipe[2] = pipe[1];
      pipe[1] = pipe[0];
      pipe[0] = cur_vec;
      log_update(pipe[2], cur_clear);
      #1;
      check_flags(viol_flags, m_flags);
      check_count(viol_count, CNT_W'(m_count));
      check_first(first_valid, first_rule, m_fv, m_first);
      if (cyc == QUIET_CYCLES && (viol_flags != '0 || viol_count != '0 || first_valid)) begin
        $display("Consistent record stream raised a violation");
        err_other++;
      end
      if (cyc == NUM_CYCLES + 3 && (viol_flags != '0 || viol_count != '0 || first_valid)) begin
        $display("Clear did not empty the violation log");
        err_other++;
      end
      if (cyc < NUM_CYCLES) begin
        make_record(cyc >= QUIET_CYCLES, r, b);
        clear = (cyc >= QUIET_CYCLES) && ($urandom_range(0, 49) == 0);
      end else begin
        r = '0;
        b = '0;
        clear = (cyc == NUM_CYCLES + 2);
      end
      predict_record(r, b, cur_vec);
      rec = r;
      bus = b;
      cur_clear = clear;
    end
    $display("Errors: %0d mismatches, %0d other", err_mismatch, err_other);
    if (err_mismatch == 0 && err_other == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

// File: vlog.f
verilog/rvfi_mon_pkg.sv
verilog/retire_capture.sv
verilog/cause_rules.sv
verilog/mem_count_rule.sv
verilog/violation_log.sv
verilog/rvfi_monitor_top.sv
tests/clk_gen.sv
tests/rvfi_monitor_checker.sv
tests/rvfi_monitor_tb.sv

// File: Makefile
TOP = rvfi_monitor_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f vlog.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f vlog.f --top-module $(TOP) -Mdir obj_dir
	@./obj_dir/V$(TOP) > sim.log 2>&1; status=$$?; cat sim.log; \
	if [ $$status -ne 0 ] || grep -q "Verification failed" sim.log; then \
	  echo "sim: FAIL"; exit 1; \
	fi
	@echo "sim: PASS"

clean:
	rm -rf obj_dir sim.log
